// ==== Makefile ====
# Verilator build and run for the Taylor series exponential unit

VERILATOR ?= verilator
ORDERS    ?= 4
# 32'h41ec_7c89 in decimal
SEED      ?= 1106017417
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
TOP       := taylor_exp_tb

VFLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP) \
          -GORDERS=$(ORDERS) -GSEED=$(SEED) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "Variables: ORDERS=$(ORDERS) SEED=$(SEED) LOG=$(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f project.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/exp_ctrl_pkg.sv ====
package exp_ctrl_pkg;

    // Term index, enough for MAX_ORDERS terms
    localparam int ORDER_IDX_WIDTH = 3;

    typedef logic [ORDER_IDX_WIDTH-1:0] order_idx_t;

    // Sequencer states
    //   IDLE  waiting for an input
    //   RUN   one term per cycle
    //   HOLD  result presented until taken
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } seq_state_t;

endpackage

// ==== logic/exp_fixed_pkg.sv ====
package exp_fixed_pkg;

    // Input x is Q3.4, powers, terms and the result are Q7.8
    localparam int IN_WIDTH   = 8;
    localparam int IN_FRAC    = 4;
    localparam int OUT_WIDTH  = 16;
    localparam int OUT_FRAC   = 8;
    localparam int COEF_WIDTH = 8;
    localparam int COEF_FRAC  = 5;
    localparam int MAX_ORDERS = 8;

    // Wide enough for power * x and for power * coefficient
    localparam int WIDE_WIDTH = OUT_WIDTH + COEF_WIDTH + 1;

    typedef logic signed [IN_WIDTH-1:0]   exp_in_t;
    typedef logic signed [OUT_WIDTH-1:0]  exp_out_t;
    typedef logic        [COEF_WIDTH-1:0] coef_t;
    typedef logic signed [WIDE_WIDTH-1:0] wide_t;

    // 1/k! with 5 fraction bits
    localparam coef_t COEF_TABLE [MAX_ORDERS] = '{
        8'd32,  // 1/0!
        8'd32,  // 1/1!
        8'd16,
        8'd5,
        8'd1,
        8'd0,
        8'd0,
        8'd0
    };

    localparam exp_out_t ONE_OUT = exp_out_t'(1 << OUT_FRAC);
    localparam exp_out_t OUT_MAX = exp_out_t'({1'b0, {(OUT_WIDTH-1){1'b1}}});
    localparam exp_out_t OUT_MIN = exp_out_t'({1'b1, {(OUT_WIDTH-1){1'b0}}});

    // Clamp a wide intermediate to the output range
    function automatic exp_out_t sat_out(input wide_t v);
        if (v > wide_t'(OUT_MAX))
            return OUT_MAX;
        if (v < wide_t'(OUT_MIN))
            return OUT_MIN;
        return exp_out_t'(v);
    endfunction

endpackage

// ==== logic/exp_sequencer.sv ====
module exp_sequencer
    import exp_ctrl_pkg::*;
#(
    parameter int ORDERS = 4
) (
    input  logic       clk,
    input  logic       arst_n,

    input  logic       in_valid,
    output logic       in_ready,

    output logic       out_valid,
    input  logic       out_ready,

    output logic       start,
    output logic       step,
    input  logic       last,

    power_term_if.ctrl term
);

    seq_state_t state;
    seq_state_t state_next;
    logic       accept;

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == HOLD);
    assign accept    = in_valid && in_ready;

    // Load x and restart the sum on the accept edge
    assign start      = accept;
    assign term.clear = accept;

    // One term per RUN cycle
    assign step         = (state == RUN);
    assign term.term_en = (state == RUN);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept)
                    state_next = RUN;
            end
            RUN: begin
                if (last)
                    state_next = HOLD;  // Final term goes in on this edge
            end
            HOLD: begin
                if (out_ready)
                    state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    a_ready_valid_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(in_ready && out_valid)
    ) else $error("in_ready and out_valid high together");

    // Result appears exactly ORDERS edges after the accept edge
    a_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        accept |-> ##ORDERS (!out_valid) ##1 out_valid
    ) else $error("out_valid not raised ORDERS edges after accept");

endmodule

// ==== logic/order_counter.sv ====
module order_counter
    import exp_ctrl_pkg::*;
#(
    parameter int ORDERS = 4
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  logic      step,
    output logic      last,

    power_term_if.cnt term
);

    localparam order_idx_t LAST_IDX = order_idx_t'(ORDERS - 1);

    order_idx_t idx;

    assign last       = (idx == LAST_IDX);
    assign term.order = idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx <= '0;
        end else if (start) begin
            idx <= '0;
        end else if (step && !last) begin
            idx <= idx + 1'b1;  // Parks on the last index
        end
    end

    a_idx_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        idx <= LAST_IDX
    ) else $error("term index %0d beyond ORDERS-1", idx);

endmodule

// ==== logic/power_step.sv ====
module power_step
    import exp_fixed_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  logic      step,
    input  exp_in_t   x,

    power_term_if.src term
);

    exp_in_t  x_q;
    exp_out_t power_q;
    wide_t    prod;
    wide_t    prod_floor;

    // Q7.8 * Q3.4 gives 12 fraction bits
    assign prod = power_q * x_q;

    // Arithmetic shift floors back to 8 fraction bits
    assign prod_floor = prod >>> IN_FRAC;

    always_ff @(posedge clk) begin
        if (start)
            x_q <= x;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            power_q <= ONE_OUT;
        end else if (start) begin
            power_q <= ONE_OUT;  // x^0
        end else if (step) begin
            power_q <= sat_out(prod_floor);
        end
    end

    assign term.power = power_q;

endmodule

// ==== logic/power_term_if.sv ====
interface power_term_if
    import exp_fixed_pkg::*, exp_ctrl_pkg::*;
();

    exp_out_t   power;    // Current power of x
    order_idx_t order;    // Index of the term being formed
    logic       term_en;  // Add this term
    logic       clear;    // Start a new sum

    modport ctrl (
        output term_en,
        output clear
    );

    modport src (
        output power
    );

    modport cnt (
        output order
    );

    modport sink (
        input power,
        input order,
        input term_en,
        input clear
    );

endinterface

// ==== logic/taylor_exp_top.sv ====
module taylor_exp_top
    import exp_fixed_pkg::*;
#(
    parameter int ORDERS = 4
) (
    input  logic     clk,
    input  logic     arst_n,

    input  exp_in_t  in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output exp_out_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    logic start;
    logic step;
    logic last;

    power_term_if term_if ();

    exp_sequencer #(
        .ORDERS(ORDERS)
    ) seq_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .start    (start),
        .step     (step),
        .last     (last),
        .term     (term_if.ctrl)
    );

    order_counter #(
        .ORDERS(ORDERS)
    ) cnt_inst (
        .clk   (clk),
        .arst_n(arst_n),
        .start (start),
        .step  (step),
        .last  (last),
        .term  (term_if.cnt)
    );

    power_step power_inst (
        .clk   (clk),
        .arst_n(arst_n),
        .start (start),
        .step  (step),
        .x     (in_data),  // Sampled on the accept edge
        .term  (term_if.src)
    );

    term_accumulator acc_inst (
        .clk   (clk),
        .arst_n(arst_n),
        .sum   (out_data),
        .term  (term_if.sink)
    );

endmodule

// ==== logic/term_accumulator.sv ====
module term_accumulator
    import exp_fixed_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    output exp_out_t   sum,

    power_term_if.sink term
);

    coef_t coef;
    wide_t scaled;
    wide_t term_val;
    wide_t sum_ext;

    assign coef = COEF_TABLE[term.order];

    // Coefficient is unsigned, so widen it with a zero sign bit
    assign scaled   = term.power * $signed({1'b0, coef});
    assign term_val = scaled >>> COEF_FRAC;  // Floor to Q7.8

    assign sum_ext = sum + term_val;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum <= '0;
        end else if (term.clear) begin
            sum <= '0;
        end else if (term.term_en) begin
            sum <= sat_out(sum_ext);
        end
    end

    // Clear comes from accept in IDLE, term_en only from RUN
    a_clear_term_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(term.clear && term.term_en)
    ) else $error("clear and term_en high together");

endmodule

// ==== project.f ====
logic/exp_fixed_pkg.sv
logic/exp_ctrl_pkg.sv
logic/power_term_if.sv
logic/exp_sequencer.sv
logic/order_counter.sv
logic/power_step.sv
logic/term_accumulator.sv
logic/taylor_exp_top.sv
tests/taylor_exp_tb.sv

// ==== tests/taylor_exp_tb.sv ====
module taylor_exp_tb
    import exp_fixed_pkg::*, exp_ctrl_pkg::*;
#(
    parameter int          ORDERS = 4,
    parameter int unsigned SEED   = 32'h41ec_7c89
);

    localparam int DRIVE_DELAY = 10;  // After the rising edge
    localparam int NUM_KNOWN   = 2;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_STALL   = 30;
    localparam int NUM_SAT     = 4;
    localparam int NUM_TESTS   = NUM_KNOWN + NUM_RANDOM + NUM_STALL + NUM_SAT;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (ORDERS + 8) + 200;

    localparam longint SAT_HI = (longint'(1) <<< (OUT_WIDTH - 1)) - 1;
    localparam longint SAT_LO = -(longint'(1) <<< (OUT_WIDTH - 1));

    logic     clk;
    logic     arst_n;
    exp_in_t  in_data;
    logic     in_valid;
    logic     in_ready;
    exp_out_t out_data;
    logic     out_valid;
    logic     out_ready;

    string test_name = "reset";
    int    exp_result = 0;
    int    value_errors = 0;
    int    proto_errors = 0;
    int    cycles = 0;
    int    transfers = 0;
    int    edges_since_accept = 0;
    logic  busy = 1'b0;  // Between accept and output transfer

    taylor_exp_top #(
        .ORDERS(ORDERS)
    ) uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic longint clamp_out(input longint v);
        if (v > SAT_HI)
            return SAT_HI;
        if (v < SAT_LO)
            return SAT_LO;
        return v;
    endfunction

    // Iterative Taylor series in plain integers giving a Q7.8 result
    function automatic int exp_model(input int x);
        longint p;
        longint s;
        longint t;
        p = 256;
        s = 0;
        for (int k = 0; k < ORDERS; k++) begin
            t = (p * longint'(int'(COEF_TABLE[k]))) >>> COEF_FRAC;
            s = clamp_out(s + t);
            p = clamp_out((p * x) >>> IN_FRAC);
        end
        return int'(s);
    endfunction

    // Edge bookkeeping for the protocol checks
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (in_valid && in_ready) begin
            busy               <= 1'b1;
            edges_since_accept <= 0;
        end else begin
            edges_since_accept <= edges_since_accept + 1;
            if (out_valid && out_ready) begin
                busy      <= 1'b0;
                transfers <= transfers + 1;
            end
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> (in_ready && !out_valid))
    else begin
        proto_errors++;
        $display("In reset the DUT is not idle with in_ready high");
    end

    a_ready_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> (in_ready && !out_valid)
    ) else begin
        proto_errors++;
        $display("Right after reset the DUT is not idle with in_ready high");
    end

    a_result: assert property (
        @(posedge clk) disable iff (!arst_n) out_valid |-> (out_data == exp_result)
    ) else begin
        value_errors++;
        $display("[ERROR] %s: expected %0d, actual %0d",
                 test_name, exp_result, $sampled(out_data));
    end

    a_latency: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(out_valid) |-> (edges_since_accept == ORDERS)
    ) else begin
        value_errors++;
        $display("[ERROR] %s latency: expected %0d, actual %0d",
                 test_name, ORDERS, $sampled(edges_since_accept));
    end

    a_busy_not_ready: assert property (@(posedge clk) disable iff (!arst_n) busy |-> !in_ready)
    else begin
        proto_errors++;
        $display("in_ready went high while a value was still in flight");
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else begin
        proto_errors++;
        $display("Result changed or dropped while out_ready was low");
    end

    a_ready_return: assert property (
        @(posedge clk) disable iff (!arst_n) (out_valid && out_ready) |=> in_ready
    ) else begin
        proto_errors++;
        $display("in_ready not high on the cycle after the output transfer");
    end

    // Sends one value through the DUT and holds out_ready low for stall cycles
    task automatic send_value(input exp_in_t x, input int stall);
        exp_result = exp_model(int'(x));
        in_data    = x;
        in_valid   = 1'b1;
        out_ready  = (stall == 0);
        while (!in_ready) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(posedge clk);  // Accept edge
        #DRIVE_DELAY;
        in_valid = 1'b0;
        while (!out_valid) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        if (stall > 0) begin
            in_data  = ~x;  // Second input offered while the result is held
            in_valid = 1'b1;
            repeat (stall) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            in_valid  = 1'b0;
            out_ready = 1'b1;
        end
        @(posedge clk);  // Output transfer
        #DRIVE_DELAY;
    endtask

    initial begin
        arst_n    = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        void'($urandom(SEED));

        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;

        test_name = "known_zero";
        send_value(8'sd0, 0);
        test_name = "known_one";
        send_value(8'sd16, 0);  // 1.0

        test_name = "random";
        repeat (NUM_RANDOM) send_value(exp_in_t'($urandom_range(0, 255)), 0);

        test_name = "backpressure";
        repeat (NUM_STALL) begin
            send_value(exp_in_t'($urandom_range(0, 255)), int'($urandom_range(0, 10)));
        end

        test_name = "saturation";
        send_value(8'sd127, 0);  // Just under 8.0
        send_value(8'sd126, 3);
        send_value(-8'sd128, 0);
        send_value(-8'sd100, 2);

        if (transfers != NUM_TESTS) begin
            proto_errors++;
            $display("Only %0d of %0d results were taken from the DUT", transfers, NUM_TESTS);
        end

        $display("Errors: value %0d, protocol %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
